//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := minmax_slice_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# The run passes only if the pass message shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/minmax_vectors.svh
// Columns: name, op, fmt, vector flag, operand a, operand b, simd mask,
// expected result, expected nv
task automatic load_vectors();
  // FP32 scalar ordering, zeros and infinity
  add_row("f32_min_mix",  op_min, f32, 0, 32'hBF800000, 32'h40000000, 2'b11, 32'hBF800000, 0);
  add_row("f32_max_mix",  op_max, f32, 0, 32'hBF800000, 32'h40000000, 2'b11, 32'h40000000, 0);
  add_row("f32_min_zero", op_min, f32, 0, 32'h00000000, 32'h80000000, 2'b11, 32'h80000000, 0);
  add_row("f32_max_zero", op_max, f32, 0, 32'h80000000, 32'h00000000, 2'b11, 32'h00000000, 0);
  add_row("f32_min_neg",  op_min, f32, 0, 32'hC0000000, 32'hBF800000, 2'b11, 32'hC0000000, 0);
  add_row("f32_max_neg",  op_max, f32, 0, 32'hC0000000, 32'hBF800000, 2'b11, 32'hBF800000, 0);
  add_row("f32_max_inf",  op_max, f32, 0, 32'h7F800000, 32'h40400000, 2'b11, 32'h7F800000, 0);
  // FP32 NaN handling
  add_row("f32_qnan_a",   op_min, f32, 0, 32'h7FC00000, 32'h3F800000, 2'b11, 32'h3F800000, 0);
  add_row("f32_snan_b",   op_max, f32, 0, 32'hC0000000, 32'h7F800001, 2'b11, 32'hC0000000, 1);
  add_row("f32_two_qnan", op_min, f32, 0, 32'h7FC00000, 32'hFFC00001, 2'b11, 32'h7FC00000, 0);
  add_row("f32_snan_qn",  op_max, f32, 0, 32'h7F800001, 32'h7FC00000, 2'b11, 32'h7FC00000, 1);
  // FP16 scalar, upper halves must be boxed away
  add_row("f16_min_scal", op_min, f16, 0, 32'h40003C00, 32'h38004000, 2'b11, 32'hFFFF3C00, 0);
  add_row("f16_max_scal", op_max, f16, 0, 32'h1234BC00, 32'h56788000, 2'b11, 32'hFFFF8000, 0);
  add_row("f16_snan_sc",  op_min, f16, 0, 32'h00007C01, 32'h0000C000, 2'b11, 32'hFFFFC000, 1);
  add_row("f16_hi_snan",  op_min, f16, 0, 32'h7C014200, 32'h7C013C00, 2'b11, 32'hFFFF3C00, 0);
  // FP16 vector, two independent lanes
  add_row("f16_vmin",     op_min, f16, 1, 32'hBC004000, 32'h3C003800, 2'b11, 32'hBC003800, 0);
  add_row("f16_vmax",     op_max, f16, 1, 32'h8000C000, 32'h0000BC00, 2'b11, 32'h0000BC00, 0);
  add_row("f16_vmax_nan", op_max, f16, 1, 32'h7E007C00, 32'h42007E00, 2'b11, 32'h42007C00, 0);
  add_row("f16_v2nan",    op_min, f16, 1, 32'h7E003C00, 32'h7C017E00, 2'b11, 32'h7E003C00, 1);
  add_row("f16_v2nan_m0", op_min, f16, 1, 32'h7E003C00, 32'h7C017E00, 2'b01, 32'h7E003C00, 0);
  add_row("f16_vsnan_m1", op_min, f16, 1, 32'h3C007C01, 32'h40003C00, 2'b10, 32'h3C003C00, 0);
  add_row("f16_vmin_neg", op_min, f16, 1, 32'h4200BC00, 32'hC0008000, 2'b11, 32'hC000BC00, 0);
  // A few more scalars after the vectors
  add_row("f32_max_pos",  op_max, f32, 0, 32'h3F000000, 32'h3F800000, 2'b11, 32'h3F800000, 0);
  add_row("f32_min_eq",   op_min, f32, 0, 32'h40400000, 32'h40400000, 2'b11, 32'h40400000, 0);
endtask

//--- dv/minmax_slice_tb.sv
`timescale 1ns/1ns

module minmax_slice_tb;

  localparam fp_slice_pkg::operation_e op_min = fp_slice_pkg::MIN;
  localparam fp_slice_pkg::operation_e op_max = fp_slice_pkg::MAX;
  localparam fp_slice_pkg::fp_format_e f32    = fp_slice_pkg::FP32;
  localparam fp_slice_pkg::fp_format_e f16    = fp_slice_pkg::FP16;

  typedef struct packed {
    fp_slice_pkg::operation_e op;
    fp_slice_pkg::fp_format_e fmt;
    logic                     vec;
    logic [31:0]              a;
    logic [31:0]              b;
    logic [1:0]               mask;
    logic [31:0]              exp_res;
    logic                     exp_nv;
  } vec_row_t;

  logic                         clk_i = 1'b0;
  logic                         rst_i;
  logic [31:0]                  operands_a_i, operands_b_i;
  fp_slice_pkg::operation_e     op_i;
  fp_slice_pkg::fp_format_e     fmt_i;
  logic                         vectorial_op_i;
  fp_slice_pkg::tag_t           tag_i;
  logic [1:0]                   simd_mask_i;
  logic                         in_valid_i, in_ready_o;
  logic [31:0]                  result_o;
  fp_slice_pkg::status_t        status_o;
  fp_slice_pkg::tag_t           tag_o;
  logic                         out_valid_o, out_ready_i;
  logic                         busy_o;

  vec_row_t rows[$];
  string    names[$];
  int       seed;
  int       error_count, check_count;
  int       out_idx;                    // Next row expected at the output
  int       cycle_count, cycle_limit;

  minmax_slice #(
    .NumPipeRegs ( 2 )
  ) dut0 (
    .clk_i, .rst_i, .operands_a_i, .operands_b_i, .op_i, .fmt_i, .vectorial_op_i,
    .tag_i, .simd_mask_i, .in_valid_i, .in_ready_o, .result_o, .status_o, .tag_o,
    .out_valid_o, .out_ready_i, .busy_o
  );

  // ------------------------------
  // Table and checks
  // ------------------------------
  task automatic add_row(input string name, input fp_slice_pkg::operation_e op,
                         input fp_slice_pkg::fp_format_e fmt, input int vec,
                         input logic [31:0] a, input logic [31:0] b,
                         input logic [1:0] mask, input logic [31:0] exp_res,
                         input int exp_nv);
    vec_row_t row;
    row.op      = op;
    row.fmt     = fmt;
    row.vec     = (vec != 0);
    row.a       = a;
    row.b       = b;
    row.mask    = mask;
    row.exp_res = exp_res;
    row.exp_nv  = (exp_nv != 0);
    rows.push_back(row);
    names.push_back(name);
  endtask

  `include "minmax_vectors.svh"

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_output(input int idx);
    check_value({names[idx], " result"}, rows[idx].exp_res, result_o);
    // Only nv may ever be raised
    check_value({names[idx], " status"}, {27'b0, rows[idx].exp_nv, 4'b0}, {27'b0, status_o});
    check_value({names[idx], " tag"}, {28'b0, idx[3:0]}, {28'b0, tag_o});
  endtask

  task automatic drive_row(input int idx);
    operands_a_i   = rows[idx].a;
    operands_b_i   = rows[idx].b;
    op_i           = rows[idx].op;
    fmt_i          = rows[idx].fmt;
    vectorial_op_i = rows[idx].vec;
    simd_mask_i    = rows[idx].mask;
    tag_i          = fp_slice_pkg::tag_t'(idx);
    in_valid_i     = 1'b1;
  endtask

  // ------------------------------
  // Clock, back-pressure, timeout
  // ------------------------------
  initial begin
    forever #4 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    out_ready_i = ($random(seed) % 4) != 0; // Ready about 3 cycles in 4
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles, %0d of %0d results seen",
               cycle_count, out_idx, rows.size());
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // In-order checker
  always @(posedge clk_i) begin
    if (!rst_i && out_valid_o && out_ready_i) begin
      if (out_idx >= rows.size()) begin
        error_count++;
        $display("Extra result after the last row, tag %0d", tag_o);
      end else begin
        compare_output(out_idx);
      end
      out_idx++;
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    rst_i          = 1'b1;
    operands_a_i   = '0;
    operands_b_i   = '0;
    op_i           = fp_slice_pkg::MIN;
    fmt_i          = fp_slice_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b0;
    seed           = 49;
    error_count    = 0;
    check_count    = 0;
    out_idx        = 0;
    cycle_count    = 0;
    load_vectors();
    cycle_limit = rows.size() * 20;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_value("reset out_valid", 32'd0, {31'b0, out_valid_o});
    check_value("reset busy", 32'd0, {31'b0, busy_o});
    check_value("reset in_ready", 32'd1, {31'b0, in_ready_o});

    for (int i = 0; i < rows.size(); i++) begin
      drive_row(i);
      @(posedge clk_i);
      while (!in_ready_o) @(posedge clk_i); // Hold until accepted
      @(negedge clk_i);
    end
    in_valid_i = 1'b0;

    wait (out_idx == rows.size());
    @(negedge clk_i);
    check_value("drained busy", 32'd0, {31'b0, busy_o});

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- logic/fp_slice_pkg.sv
package fp_slice_pkg;

  // ------------------------------
  // Slice geometry
  // ------------------------------
  localparam int unsigned WIDTH     = 32;
  localparam int unsigned NUM_LANES = 2;
  localparam int unsigned FP16_W    = 16; // Narrow format width

  // ------------------------------
  // Formats and opcodes
  // ------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // One bit per format, indexed by fp_format_e
  typedef logic [1:0] fmt_mask_t;

  typedef enum logic {
    MIN = 1'b0,
    MAX = 1'b1
  } operation_e;

  // IEEE exception flags, only nv is raised by MIN/MAX
  typedef struct packed {
    logic nv; // Invalid operation
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  typedef logic [3:0] tag_t;

  // Travels with lane 0 only
  typedef struct packed {
    fp_format_e fmt; // Destination format
    logic       vec; // Vector op, lane 1 holds a result
    tag_t       tag;
  } slice_aux_t;

  typedef struct packed {
    logic [WIDTH-1:0] result;
    status_t          status;
  } lane_res_t;

endpackage

//--- logic/lane_pipe.sv
`timescale 1ns/1ns

module lane_pipe #(
  parameter int unsigned NumPipeRegs  = 2,
  parameter int unsigned PayloadWidth = 37
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [PayloadWidth-1:0] in_data_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output logic [PayloadWidth-1:0] out_data_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  // Index i holds the item after i register stages
  logic [0:NumPipeRegs][PayloadWidth-1:0] stage_data;
  logic [0:NumPipeRegs]                   stage_valid;
  logic [0:NumPipeRegs]                   stage_ready;

  assign stage_data[0]  = in_data_i;
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic                    valid_q;
    logic [PayloadWidth-1:0] data_q;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        data_q <= stage_data[i]; // Only load real items
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  // ------------------------------
  // Output side
  // ------------------------------
  assign stage_ready[NumPipeRegs] = out_ready_i;

  assign in_ready_o  = stage_ready[0];
  assign out_data_o  = stage_data[NumPipeRegs];
  assign out_valid_o = stage_valid[NumPipeRegs];
  assign busy_o      = |stage_valid;

endmodule

//--- logic/minmax_lane.sv
`timescale 1ns/1ns

module minmax_lane #(
  parameter int unsigned             LaneWidth   = 32,
  parameter fp_slice_pkg::fmt_mask_t LaneFormats = 2'b11
) (
  input  logic [LaneWidth-1:0]     a_i,
  input  logic [LaneWidth-1:0]     b_i,
  input  fp_slice_pkg::operation_e op_i,
  input  fp_slice_pkg::fp_format_e fmt_i,
  output fp_slice_pkg::lane_res_t  res_o
);

  localparam int unsigned W = fp_slice_pkg::WIDTH;
  localparam int unsigned H = fp_slice_pkg::FP16_W;

  logic [W-1:0] a_ext, b_ext;   // Operands widened to the slice width
  logic         is_wide;        // FP32 layout selected
  logic         a_sign, b_sign;
  logic [W-2:0] a_mag, b_mag;
  logic [1:0]   a_cls, b_cls;   // {nan, snan}
  logic         a_lt_b;
  logic [W-1:0] a_box, b_box;
  logic [W-1:0] canon_nan;

  // Returns {is NaN, is signaling NaN}
  function automatic logic [1:0] classify(logic [W-1:0] x, logic wide);
    logic exp_ones;
    logic man_nz;
    logic quiet;
    if (wide) begin
      exp_ones = &x[30:23];
      man_nz   = |x[22:0];
      quiet    = x[22];
    end else begin
      exp_ones = &x[14:10];
      man_nz   = |x[9:0];
      quiet    = x[9];
    end
    return {exp_ones & man_nz, exp_ones & man_nz & ~quiet};
  endfunction

  always_comb begin
    a_ext = '0;
    b_ext = '0;
    a_ext[LaneWidth-1:0] = a_i;
    b_ext[LaneWidth-1:0] = b_i;
  end

  // A lane without FP32 support always reads FP16
  assign is_wide = LaneFormats[fp_slice_pkg::FP32] && (fmt_i == fp_slice_pkg::FP32);

  assign a_cls = classify(a_ext, is_wide);
  assign b_cls = classify(b_ext, is_wide);

  assign a_sign = is_wide ? a_ext[W-1] : a_ext[H-1];
  assign b_sign = is_wide ? b_ext[W-1] : b_ext[H-1];
  assign a_mag  = is_wide ? a_ext[W-2:0] : {{(W-H){1'b0}}, a_ext[H-2:0]};
  assign b_mag  = is_wide ? b_ext[W-2:0] : {{(W-H){1'b0}}, b_ext[H-2:0]};

  // Sign first, so -0 sorts below +0
  always_comb begin
    if (a_sign != b_sign) begin
      a_lt_b = a_sign;
    end else if (a_sign) begin
      a_lt_b = a_mag > b_mag;   // Both negative, larger magnitude is smaller
    end else begin
      a_lt_b = a_mag < b_mag;
    end
  end

  // FP16 results leave the lane already NaN-boxed
  assign a_box     = is_wide ? a_ext : {{(W-H){1'b1}}, a_ext[H-1:0]};
  assign b_box     = is_wide ? b_ext : {{(W-H){1'b1}}, b_ext[H-1:0]};
  assign canon_nan = is_wide ? 32'h7FC0_0000 : 32'hFFFF_7E00;

  always_comb begin
    res_o           = '0;
    res_o.status.nv = a_cls[0] | b_cls[0];
    if (a_cls[1] && b_cls[1]) begin
      res_o.result = canon_nan;
    end else if (a_cls[1]) begin
      res_o.result = b_box;
    end else if (b_cls[1]) begin
      res_o.result = a_box;
    end else if ((op_i == fp_slice_pkg::MIN) == a_lt_b) begin
      res_o.result = a_box; // MIN with a<b, or MAX with a>=b
    end else begin
      res_o.result = b_box;
    end
  end

endmodule

//--- logic/minmax_slice.sv
`timescale 1ns/1ns

module minmax_slice #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [fp_slice_pkg::WIDTH-1:0]     operands_a_i,
  input  logic [fp_slice_pkg::WIDTH-1:0]     operands_b_i,
  input  fp_slice_pkg::operation_e           op_i,
  input  fp_slice_pkg::fp_format_e           fmt_i,
  input  logic                               vectorial_op_i,
  input  fp_slice_pkg::tag_t                 tag_i,
  input  logic [fp_slice_pkg::NUM_LANES-1:0] simd_mask_i,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  output logic [fp_slice_pkg::WIDTH-1:0]     result_o,
  output fp_slice_pkg::status_t              status_o,
  output fp_slice_pkg::tag_t                 tag_o,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output logic                               busy_o
);

  localparam int unsigned NumLanes = fp_slice_pkg::NUM_LANES;

  // Lane 0 payload carries the aux data as well
  typedef struct packed {
    fp_slice_pkg::slice_aux_t aux;
    logic                     mask;
    fp_slice_pkg::lane_res_t  res;
  } head_pay_t;

  typedef struct packed {
    logic                    mask;
    fp_slice_pkg::lane_res_t res;
  } tail_pay_t;

  fp_slice_pkg::lane_res_t [NumLanes-1:0] lane_res;
  fp_slice_pkg::slice_aux_t               aux_in;
  head_pay_t                              head_in, head_out;
  tail_pay_t                              tail_in, tail_out;
  logic [NumLanes-1:0] lane_in_valid, lane_in_ready;
  logic [NumLanes-1:0] lane_out_valid, lane_busy;
  logic                tail_out_ready;
  logic                lane1_used;  // Vector FP16 op
  logic [5:0]          fmt_width;

  // ------------------------------
  // Input side
  // ------------------------------
  assign lane1_used = vectorial_op_i & (fmt_i == fp_slice_pkg::FP16);
  assign fmt_width  = (fmt_i == fp_slice_pkg::FP16) ? 6'(fp_slice_pkg::FP16_W)
                                                    : 6'(fp_slice_pkg::WIDTH);

  assign aux_in.fmt = fmt_i;
  assign aux_in.vec = lane1_used;
  assign aux_in.tag = tag_i;

  assign lane_in_valid[0] = in_valid_i;
  // Lane 1 only loads when lane 0 takes the same item
  assign lane_in_valid[1] = in_valid_i & lane1_used & lane_in_ready[0];

  for (genvar lane = 0; lane < NumLanes; lane++) begin : gen_lanes
    // Lane 0 spans the slice while upper lanes hold FP16 only
    localparam int unsigned LaneW = (lane == 0) ? fp_slice_pkg::WIDTH : fp_slice_pkg::FP16_W;
    localparam fp_slice_pkg::fmt_mask_t LaneFmts = (lane == 0) ? 2'b11 : 2'b10;

    logic [fp_slice_pkg::WIDTH-1:0] local_a, local_b;

    assign local_a = operands_a_i >> (lane * fmt_width);
    assign local_b = operands_b_i >> (lane * fmt_width);

    minmax_lane #(
      .LaneWidth   ( LaneW    ),
      .LaneFormats ( LaneFmts )
    ) u_lane (
      .a_i   ( local_a[LaneW-1:0] ),
      .b_i   ( local_b[LaneW-1:0] ),
      .op_i  ( op_i               ),
      .fmt_i ( fmt_i              ),
      .res_o ( lane_res[lane]     )
    );
  end

  assign head_in = '{aux: aux_in, mask: simd_mask_i[0], res: lane_res[0]};
  assign tail_in = '{mask: simd_mask_i[1], res: lane_res[1]};

  // ------------------------------
  // Lane pipelines
  // ------------------------------
  lane_pipe #(
    .NumPipeRegs  ( NumPipeRegs        ),
    .PayloadWidth ( $bits(head_pay_t)  )
  ) u_pipe0 (
    .clk_i       ( clk_i             ),
    .rst_i       ( rst_i             ),
    .in_data_i   ( head_in           ),
    .in_valid_i  ( lane_in_valid[0]  ),
    .in_ready_o  ( lane_in_ready[0]  ),
    .out_data_o  ( head_out          ),
    .out_valid_o ( lane_out_valid[0] ),
    .out_ready_i ( out_ready_i       ),
    .busy_o      ( lane_busy[0]      )
  );

  // Lane 1 drains only alongside a vector item at lane 0's head
  assign tail_out_ready = out_ready_i & head_out.aux.vec;

  lane_pipe #(
    .NumPipeRegs  ( NumPipeRegs        ),
    .PayloadWidth ( $bits(tail_pay_t)  )
  ) u_pipe1 (
    .clk_i       ( clk_i             ),
    .rst_i       ( rst_i             ),
    .in_data_i   ( tail_in           ),
    .in_valid_i  ( lane_in_valid[1]  ),
    .in_ready_o  ( lane_in_ready[1]  ),
    .out_data_o  ( tail_out          ),
    .out_valid_o ( lane_out_valid[1] ),
    .out_ready_i ( tail_out_ready    ),
    .busy_o      ( lane_busy[1]      )
  );

  // ------------------------------
  // Output side
  // ------------------------------
  result_pack u_pack (
    .lane0_i       ( head_out.res                           ),
    .lane1_i       ( tail_out.res                           ),
    .lane1_valid_i ( lane_out_valid[1]                      ),
    .mask_i        ( {tail_out.mask, head_out.mask}         ),
    .aux_i         ( head_out.aux                           ),
    .result_o      ( result_o                               ),
    .status_o      ( status_o                               ),
    .tag_o         ( tag_o                                  )
  );

  assign in_ready_o  = lane_in_ready[0];   // Upstream follows lane 0
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

//--- logic/result_pack.sv
`timescale 1ns/1ns

module result_pack (
  input  fp_slice_pkg::lane_res_t              lane0_i,
  input  fp_slice_pkg::lane_res_t              lane1_i,
  input  logic                                 lane1_valid_i,
  input  logic [fp_slice_pkg::NUM_LANES-1:0]   mask_i,
  input  fp_slice_pkg::slice_aux_t             aux_i,
  output logic [fp_slice_pkg::WIDTH-1:0]       result_o,
  output fp_slice_pkg::status_t                status_o,
  output fp_slice_pkg::tag_t                   tag_o
);

  localparam int unsigned H  = fp_slice_pkg::FP16_W;
  localparam int unsigned SW = $bits(fp_slice_pkg::status_t);

  logic         use_lane1;   // Upper half comes from lane 1
  logic [H-1:0] upper_half;
  logic [SW-1:0] lane0_flags, lane1_flags;

  assign use_lane1  = lane1_valid_i & aux_i.vec;
  assign upper_half = use_lane1 ? lane1_i.result[H-1:0] : {H{1'b1}}; // NaN box

  // ------------------------------
  // Result by format
  // ------------------------------
  always_comb begin
    if (aux_i.fmt == fp_slice_pkg::FP32) begin
      result_o = lane0_i.result;
    end else begin
      result_o = {upper_half, lane0_i.result[H-1:0]};
    end
  end

  // Masked lanes do not report flags
  assign lane0_flags = lane0_i.status & {SW{mask_i[0]}};
  assign lane1_flags = lane1_i.status & {SW{mask_i[1] & use_lane1}};

  assign status_o = fp_slice_pkg::status_t'(lane0_flags | lane1_flags);
  assign tag_o    = aux_i.tag;

endmodule

//--- verilog.f
+incdir+dv
logic/fp_slice_pkg.sv
logic/minmax_lane.sv
logic/lane_pipe.sv
logic/result_pack.sv
logic/minmax_slice.sv
dv/minmax_slice_tb.sv
